/* hw/io_tile_pkg.sv */
package io_tile_pkg;

  localparam int paddr_width = 16;
  localparam int data_width = 32;
  localparam int did_width = 3;
  localparam int lce_id_width = 2;
  localparam int offset_width = paddr_width - did_width;

  // The same encoding serves requests and commands
  // LCE commands read it as data return or store ack
  localparam logic op_load = 1'b0;
  localparam logic op_store = 1'b1;

  // Host window spans host_base_addr up to but not including dev_base_addr
  localparam logic [paddr_width-1:0] host_base_addr = 16'h1000;
  localparam logic [paddr_width-1:0] dev_base_addr = 16'h2000;
  localparam logic [did_width-1:0] host_did = '1;

  localparam int fifo_els = 2;

  // Both engines step through these in order and wrap back to idle
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_send = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;
  localparam logic [1:0] st_reply = 2'd3;

  typedef union packed {
    logic [paddr_width-1:0] raw;
    struct packed {
      logic [did_width-1:0] did;
      logic [offset_width-1:0] offset;
    } f;
  } io_addr_u;

endpackage

/* hw/io_msg_fifo.sv */
`timescale 1ns/1ps

module io_msg_fifo (
  input  logic clk_i,
  input  logic rst_i,
  input  logic v_i,
  input  logic [io_tile_pkg::did_width-1:0] src_did_i,
  input  logic [io_tile_pkg::did_width-1:0] dst_did_i,
  input  logic op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] addr_i,
  input  logic [io_tile_pkg::data_width-1:0] data_i,
  output logic ready_o,
  output logic v_o,
  output logic [io_tile_pkg::did_width-1:0] src_did_o,
  output logic [io_tile_pkg::did_width-1:0] dst_did_o,
  output logic op_o,
  output logic [io_tile_pkg::paddr_width-1:0] addr_o,
  output logic [io_tile_pkg::data_width-1:0] data_o,
  input  logic yumi_i
);

  import io_tile_pkg::*;

  logic [did_width-1:0] src_did_mem [fifo_els];
  logic [did_width-1:0] dst_did_mem [fifo_els];
  logic op_mem [fifo_els];
  logic [paddr_width-1:0] addr_mem [fifo_els];
  logic [data_width-1:0] data_mem [fifo_els];
  logic wr_ptr_r;
  logic rd_ptr_r;
  logic [1:0] count_r;
  logic push;

  assign ready_o = (count_r != 2'(fifo_els));
  assign v_o = (count_r != 2'd0);
  assign push = v_i & ready_o;

  assign src_did_o = src_did_mem[rd_ptr_r];
  assign dst_did_o = dst_did_mem[rd_ptr_r];
  assign op_o = op_mem[rd_ptr_r];
  assign addr_o = addr_mem[rd_ptr_r];
  assign data_o = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push) begin
      src_did_mem[wr_ptr_r] <= src_did_i;
      dst_did_mem[wr_ptr_r] <= dst_did_i;
      op_mem[wr_ptr_r] <= op_i;
      addr_mem[wr_ptr_r] <= addr_i;
      data_mem[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r <= 2'd0;
    end else begin
      wr_ptr_r <= wr_ptr_r ^ push;
      rd_ptr_r <= rd_ptr_r ^ yumi_i;
      count_r <= count_r + 2'(push) - 2'(yumi_i);
    end
  end

  // The consumer may only take what is on offer
  assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o)
    else $error("io_msg_fifo: yumi without valid");

  // A message that meets a full buffer waits unchanged for room
  assert property (@(posedge clk_i) disable iff (rst_i)
                   v_i && !ready_o |=> v_i && $stable(addr_i) && $stable(data_i))
    else $error("io_msg_fifo: message lost while full");

endmodule

/* hw/io_cce.sv */
`timescale 1ns/1ps

module io_cce (
  input  logic clk_i,
  input  logic rst_i,

  input  logic lce_req_v_i,
  input  logic [io_tile_pkg::lce_id_width-1:0] lce_req_lce_id_i,
  input  logic lce_req_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] lce_req_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] lce_req_data_i,
  output logic lce_req_yumi_o,

  output logic io_cmd_v_o,
  output logic io_cmd_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] io_cmd_addr_o,
  output logic [io_tile_pkg::data_width-1:0] io_cmd_data_o,
  input  logic io_cmd_ready_i,

  input  logic io_resp_v_i,
  input  logic [io_tile_pkg::data_width-1:0] io_resp_data_i,
  output logic io_resp_yumi_o,

  output logic lce_cmd_v_o,
  output logic [io_tile_pkg::lce_id_width-1:0] lce_cmd_lce_id_o,
  output logic lce_cmd_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] lce_cmd_addr_o,
  output logic [io_tile_pkg::data_width-1:0] lce_cmd_data_o,
  input  logic lce_cmd_ready_i
);

  import io_tile_pkg::*;

  logic [1:0] state_r;
  logic [lce_id_width-1:0] lce_id_r;
  logic op_r;
  logic [paddr_width-1:0] addr_r;
  logic [data_width-1:0] data_r;
  logic step;

  assign lce_req_yumi_o = lce_req_v_i & (state_r == st_idle);
  assign io_resp_yumi_o = io_resp_v_i & (state_r == st_wait);

  assign io_cmd_v_o = (state_r == st_send);
  assign io_cmd_op_o = op_r;
  assign io_cmd_addr_o = addr_r;
  assign io_cmd_data_o = data_r;

  assign lce_cmd_v_o = (state_r == st_reply);
  assign lce_cmd_lce_id_o = lce_id_r;
  assign lce_cmd_op_o = op_r;
  assign lce_cmd_addr_o = addr_r;
  assign lce_cmd_data_o = data_r;

  // Each state ends on its own handshake
  assign step = lce_req_yumi_o | (io_cmd_v_o & io_cmd_ready_i) | io_resp_yumi_o
              | (lce_cmd_v_o & lce_cmd_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= st_idle;
    end else if (step) begin
      state_r <= state_r + 2'd1;
    end
  end

  // The data register carries store data out and load data back
  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      lce_id_r <= lce_req_lce_id_i;
      op_r <= lce_req_op_i;
      addr_r <= lce_req_addr_i;
      data_r <= lce_req_data_i;
    end else if (io_resp_yumi_o) begin
      data_r <= (op_r == op_load) ? io_resp_data_i : '0;
    end
  end

  // A device response only ever answers a command this engine sent
  assert property (@(posedge clk_i) disable iff (rst_i) (state_r == st_idle) |-> !io_resp_v_i)
    else $error("io_cce: response with no command outstanding");

endmodule

/* hw/io_lce_link.sv */
`timescale 1ns/1ps

module io_lce_link (
  input  logic clk_i,
  input  logic rst_i,
  input  logic [io_tile_pkg::lce_id_width-1:0] lce_id_i,

  input  logic io_cmd_v_i,
  input  logic [io_tile_pkg::did_width-1:0] io_cmd_src_did_i,
  input  logic io_cmd_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] io_cmd_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] io_cmd_data_i,
  output logic io_cmd_yumi_o,

  output logic lce_req_v_o,
  output logic [io_tile_pkg::lce_id_width-1:0] lce_req_lce_id_o,
  output logic lce_req_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] lce_req_addr_o,
  output logic [io_tile_pkg::data_width-1:0] lce_req_data_o,
  input  logic lce_req_ready_i,

  input  logic lce_cmd_v_i,
  input  logic [io_tile_pkg::data_width-1:0] lce_cmd_data_i,
  output logic lce_cmd_yumi_o,

  output logic io_resp_v_o,
  output logic [io_tile_pkg::did_width-1:0] io_resp_dst_did_o,
  output logic io_resp_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] io_resp_addr_o,
  output logic [io_tile_pkg::data_width-1:0] io_resp_data_o,
  input  logic io_resp_ready_i
);

  import io_tile_pkg::*;

  logic [1:0] state_r;
  logic [did_width-1:0] src_did_r;
  logic op_r;
  logic [paddr_width-1:0] addr_r;
  logic [data_width-1:0] data_r;
  logic step;

  assign io_cmd_yumi_o = io_cmd_v_i & (state_r == st_idle);
  assign lce_cmd_yumi_o = lce_cmd_v_i & (state_r == st_wait);

  assign lce_req_v_o = (state_r == st_send);
  assign lce_req_lce_id_o = lce_id_i;
  assign lce_req_op_o = op_r;
  assign lce_req_addr_o = addr_r;
  assign lce_req_data_o = data_r;

  // Response goes back to whichever device sent the command
  assign io_resp_v_o = (state_r == st_reply);
  assign io_resp_dst_did_o = src_did_r;
  assign io_resp_op_o = op_r;
  assign io_resp_addr_o = addr_r;
  assign io_resp_data_o = data_r;

  assign step = io_cmd_yumi_o | (lce_req_v_o & lce_req_ready_i) | lce_cmd_yumi_o
              | (io_resp_v_o & io_resp_ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= st_idle;
    end else if (step) begin
      state_r <= state_r + 2'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (io_cmd_yumi_o) begin
      src_did_r <= io_cmd_src_did_i;
      op_r <= io_cmd_op_i;
      addr_r <= io_cmd_addr_i;
      data_r <= io_cmd_data_i;
    end else if (lce_cmd_yumi_o) begin
      data_r <= lce_cmd_data_i;
    end
  end

  // One request at a time, so no LCE command shows up unasked
  assert property (@(posedge clk_i) disable iff (rst_i) (state_r == st_idle) |-> !lce_cmd_v_i)
    else $error("io_lce_link: LCE command with no request outstanding");

endmodule

/* hw/io_noc_link.sv */
`timescale 1ns/1ps

module io_noc_link (
  input  logic clk_i,
  input  logic rst_i,
  input  logic [io_tile_pkg::did_width-1:0] my_did_i,

  input  logic cce_io_cmd_v_i,
  input  logic cce_io_cmd_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] cce_io_cmd_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] cce_io_cmd_data_i,
  output logic cce_io_cmd_ready_o,

  output logic cce_io_resp_v_o,
  output logic [io_tile_pkg::data_width-1:0] cce_io_resp_data_o,
  input  logic cce_io_resp_yumi_i,

  output logic link_io_cmd_v_o,
  output logic [io_tile_pkg::did_width-1:0] link_io_cmd_src_did_o,
  output logic link_io_cmd_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] link_io_cmd_addr_o,
  output logic [io_tile_pkg::data_width-1:0] link_io_cmd_data_o,
  input  logic link_io_cmd_yumi_i,

  input  logic link_io_resp_v_i,
  input  logic [io_tile_pkg::did_width-1:0] link_io_resp_dst_did_i,
  input  logic link_io_resp_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] link_io_resp_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] link_io_resp_data_i,
  output logic link_io_resp_ready_o,

  output logic io_cmd_v_o,
  output logic [io_tile_pkg::did_width-1:0] io_cmd_src_did_o,
  output logic [io_tile_pkg::did_width-1:0] io_cmd_dst_did_o,
  output logic io_cmd_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] io_cmd_addr_o,
  output logic [io_tile_pkg::data_width-1:0] io_cmd_data_o,
  input  logic io_cmd_ready_i,

  input  logic io_cmd_v_i,
  input  logic [io_tile_pkg::did_width-1:0] io_cmd_src_did_i,
  input  logic [io_tile_pkg::did_width-1:0] io_cmd_dst_did_i,
  input  logic io_cmd_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] io_cmd_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] io_cmd_data_i,
  output logic io_cmd_ready_o,

  output logic io_resp_v_o,
  output logic [io_tile_pkg::did_width-1:0] io_resp_src_did_o,
  output logic [io_tile_pkg::did_width-1:0] io_resp_dst_did_o,
  output logic io_resp_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] io_resp_addr_o,
  output logic [io_tile_pkg::data_width-1:0] io_resp_data_o,
  input  logic io_resp_ready_i,

  input  logic io_resp_v_i,
  input  logic [io_tile_pkg::did_width-1:0] io_resp_src_did_i,
  input  logic [io_tile_pkg::did_width-1:0] io_resp_dst_did_i,
  input  logic io_resp_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] io_resp_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] io_resp_data_i,
  output logic io_resp_ready_o
);

  import io_tile_pkg::*;

  io_addr_u cmd_addr;
  logic is_host_addr;
  logic [did_width-1:0] cmd_dst_did;

  // Host window goes to the host, anything else to the device in the top bits
  assign cmd_addr.raw = cce_io_cmd_addr_i;
  assign is_host_addr = (cmd_addr.raw >= host_base_addr) && (cmd_addr.raw < dev_base_addr);
  assign cmd_dst_did = is_host_addr ? host_did : cmd_addr.f.did;

  io_msg_fifo out_cmd_fifo (
    .clk_i(clk_i), .rst_i(rst_i),
    .v_i(cce_io_cmd_v_i), .ready_o(cce_io_cmd_ready_o),
    .src_did_i(my_did_i), .dst_did_i(cmd_dst_did), .op_i(cce_io_cmd_op_i),
    .addr_i(cce_io_cmd_addr_i), .data_i(cce_io_cmd_data_i),
    .v_o(io_cmd_v_o), .yumi_i(io_cmd_v_o & io_cmd_ready_i),
    .src_did_o(io_cmd_src_did_o), .dst_did_o(io_cmd_dst_did_o), .op_o(io_cmd_op_o),
    .addr_o(io_cmd_addr_o), .data_o(io_cmd_data_o)
  );

  // The engine only needs the payload of a response
  io_msg_fifo in_resp_fifo (
    .clk_i(clk_i), .rst_i(rst_i),
    .v_i(io_resp_v_i), .ready_o(io_resp_ready_o),
    .src_did_i(io_resp_src_did_i), .dst_did_i(io_resp_dst_did_i), .op_i(io_resp_op_i),
    .addr_i(io_resp_addr_i), .data_i(io_resp_data_i),
    .v_o(cce_io_resp_v_o), .yumi_i(cce_io_resp_yumi_i),
    .src_did_o(), .dst_did_o(), .op_o(),
    .addr_o(), .data_o(cce_io_resp_data_o)
  );

  io_msg_fifo in_cmd_fifo (
    .clk_i(clk_i), .rst_i(rst_i),
    .v_i(io_cmd_v_i), .ready_o(io_cmd_ready_o),
    .src_did_i(io_cmd_src_did_i), .dst_did_i(io_cmd_dst_did_i), .op_i(io_cmd_op_i),
    .addr_i(io_cmd_addr_i), .data_i(io_cmd_data_i),
    .v_o(link_io_cmd_v_o), .yumi_i(link_io_cmd_yumi_i),
    .src_did_o(link_io_cmd_src_did_o), .dst_did_o(), .op_o(link_io_cmd_op_o),
    .addr_o(link_io_cmd_addr_o), .data_o(link_io_cmd_data_o)
  );

  io_msg_fifo out_resp_fifo (
    .clk_i(clk_i), .rst_i(rst_i),
    .v_i(link_io_resp_v_i), .ready_o(link_io_resp_ready_o),
    .src_did_i(my_did_i), .dst_did_i(link_io_resp_dst_did_i), .op_i(link_io_resp_op_i),
    .addr_i(link_io_resp_addr_i), .data_i(link_io_resp_data_i),
    .v_o(io_resp_v_o), .yumi_i(io_resp_v_o & io_resp_ready_i),
    .src_did_o(io_resp_src_did_o), .dst_did_o(io_resp_dst_did_o), .op_o(io_resp_op_o),
    .addr_o(io_resp_addr_o), .data_o(io_resp_data_o)
  );

  // The network must only deliver commands meant for this tile
  assert property (@(posedge clk_i) disable iff (rst_i) io_cmd_v_i |-> io_cmd_dst_did_i == my_did_i)
    else $error("io_noc_link: inbound command for another device");

endmodule

/* hw/io_tile_top.sv */
`timescale 1ns/1ps

module io_tile_top (
  input  logic clk_i,
  input  logic rst_i,
  input  logic [io_tile_pkg::did_width-1:0] my_did_i,
  input  logic [io_tile_pkg::lce_id_width-1:0] my_lce_id_i,

  input  logic lce_req_v_i,
  input  logic [io_tile_pkg::lce_id_width-1:0] lce_req_lce_id_i,
  input  logic lce_req_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] lce_req_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] lce_req_data_i,
  output logic lce_req_yumi_o,

  output logic lce_cmd_v_o,
  output logic [io_tile_pkg::lce_id_width-1:0] lce_cmd_lce_id_o,
  output logic lce_cmd_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] lce_cmd_addr_o,
  output logic [io_tile_pkg::data_width-1:0] lce_cmd_data_o,
  input  logic lce_cmd_ready_i,

  output logic lce_req_v_o,
  output logic [io_tile_pkg::lce_id_width-1:0] lce_req_lce_id_o,
  output logic lce_req_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] lce_req_addr_o,
  output logic [io_tile_pkg::data_width-1:0] lce_req_data_o,
  input  logic lce_req_ready_i,

  input  logic lce_cmd_v_i,
  input  logic [io_tile_pkg::data_width-1:0] lce_cmd_data_i,
  output logic lce_cmd_yumi_o,

  output logic io_cmd_v_o,
  output logic [io_tile_pkg::did_width-1:0] io_cmd_src_did_o,
  output logic [io_tile_pkg::did_width-1:0] io_cmd_dst_did_o,
  output logic io_cmd_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] io_cmd_addr_o,
  output logic [io_tile_pkg::data_width-1:0] io_cmd_data_o,
  input  logic io_cmd_ready_i,

  input  logic io_resp_v_i,
  input  logic [io_tile_pkg::did_width-1:0] io_resp_src_did_i,
  input  logic [io_tile_pkg::did_width-1:0] io_resp_dst_did_i,
  input  logic io_resp_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] io_resp_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] io_resp_data_i,
  output logic io_resp_ready_o,

  input  logic io_cmd_v_i,
  input  logic [io_tile_pkg::did_width-1:0] io_cmd_src_did_i,
  input  logic [io_tile_pkg::did_width-1:0] io_cmd_dst_did_i,
  input  logic io_cmd_op_i,
  input  logic [io_tile_pkg::paddr_width-1:0] io_cmd_addr_i,
  input  logic [io_tile_pkg::data_width-1:0] io_cmd_data_i,
  output logic io_cmd_ready_o,

  output logic io_resp_v_o,
  output logic [io_tile_pkg::did_width-1:0] io_resp_src_did_o,
  output logic [io_tile_pkg::did_width-1:0] io_resp_dst_did_o,
  output logic io_resp_op_o,
  output logic [io_tile_pkg::paddr_width-1:0] io_resp_addr_o,
  output logic [io_tile_pkg::data_width-1:0] io_resp_data_o,
  input  logic io_resp_ready_i
);

  import io_tile_pkg::*;

  logic cce_io_cmd_v_lo;
  logic cce_io_cmd_op_lo;
  logic [paddr_width-1:0] cce_io_cmd_addr_lo;
  logic [data_width-1:0] cce_io_cmd_data_lo;
  logic cce_io_cmd_ready_li;
  logic cce_io_resp_v_li;
  logic [data_width-1:0] cce_io_resp_data_li;
  logic cce_io_resp_yumi_lo;

  logic link_io_cmd_v_li;
  logic [did_width-1:0] link_io_cmd_src_did_li;
  logic link_io_cmd_op_li;
  logic [paddr_width-1:0] link_io_cmd_addr_li;
  logic [data_width-1:0] link_io_cmd_data_li;
  logic link_io_cmd_yumi_lo;
  logic link_io_resp_v_lo;
  logic [did_width-1:0] link_io_resp_dst_did_lo;
  logic link_io_resp_op_lo;
  logic [paddr_width-1:0] link_io_resp_addr_lo;
  logic [data_width-1:0] link_io_resp_data_lo;
  logic link_io_resp_ready_li;

  // LCE-side ports share their names with the tile ports
  io_cce cce (
    .io_cmd_v_o(cce_io_cmd_v_lo),
    .io_cmd_op_o(cce_io_cmd_op_lo),
    .io_cmd_addr_o(cce_io_cmd_addr_lo),
    .io_cmd_data_o(cce_io_cmd_data_lo),
    .io_cmd_ready_i(cce_io_cmd_ready_li),
    .io_resp_v_i(cce_io_resp_v_li),
    .io_resp_data_i(cce_io_resp_data_li),
    .io_resp_yumi_o(cce_io_resp_yumi_lo),
    .*
  );

  io_lce_link lce_link (
    .lce_id_i(my_lce_id_i),
    .io_cmd_v_i(link_io_cmd_v_li),
    .io_cmd_src_did_i(link_io_cmd_src_did_li),
    .io_cmd_op_i(link_io_cmd_op_li),
    .io_cmd_addr_i(link_io_cmd_addr_li),
    .io_cmd_data_i(link_io_cmd_data_li),
    .io_cmd_yumi_o(link_io_cmd_yumi_lo),
    .io_resp_v_o(link_io_resp_v_lo),
    .io_resp_dst_did_o(link_io_resp_dst_did_lo),
    .io_resp_op_o(link_io_resp_op_lo),
    .io_resp_addr_o(link_io_resp_addr_lo),
    .io_resp_data_o(link_io_resp_data_lo),
    .io_resp_ready_i(link_io_resp_ready_li),
    .*
  );

  io_noc_link noc_link (
    .cce_io_cmd_v_i(cce_io_cmd_v_lo),
    .cce_io_cmd_op_i(cce_io_cmd_op_lo),
    .cce_io_cmd_addr_i(cce_io_cmd_addr_lo),
    .cce_io_cmd_data_i(cce_io_cmd_data_lo),
    .cce_io_cmd_ready_o(cce_io_cmd_ready_li),
    .cce_io_resp_v_o(cce_io_resp_v_li),
    .cce_io_resp_data_o(cce_io_resp_data_li),
    .cce_io_resp_yumi_i(cce_io_resp_yumi_lo),
    .link_io_cmd_v_o(link_io_cmd_v_li),
    .link_io_cmd_src_did_o(link_io_cmd_src_did_li),
    .link_io_cmd_op_o(link_io_cmd_op_li),
    .link_io_cmd_addr_o(link_io_cmd_addr_li),
    .link_io_cmd_data_o(link_io_cmd_data_li),
    .link_io_cmd_yumi_i(link_io_cmd_yumi_lo),
    .link_io_resp_v_i(link_io_resp_v_lo),
    .link_io_resp_dst_did_i(link_io_resp_dst_did_lo),
    .link_io_resp_op_i(link_io_resp_op_lo),
    .link_io_resp_addr_i(link_io_resp_addr_lo),
    .link_io_resp_data_i(link_io_resp_data_lo),
    .link_io_resp_ready_o(link_io_resp_ready_li),
    .*
  );

endmodule

/* bench/tb_io_tile.sv */
`timescale 1ns/1ps

module tb_io_tile;

  import io_tile_pkg::*;

  localparam int clk_period = 4;
  localparam int reset_cycles = 5;
  // Three single transactions, three under back-pressure and sixteen random ones
  localparam int test_len = 22;
  localparam int watchdog_cycles = test_len * 50 + reset_cycles;

  // Group selectors for the tile's outputs and inputs
  localparam int out_io_cmd = 0;
  localparam int out_lce_cmd = 1;
  localparam int out_lce_req = 2;
  localparam int out_io_resp = 3;
  localparam int in_lce_req = 0;
  localparam int in_io_resp = 1;
  localparam int in_io_cmd = 2;
  localparam int in_lce_cmd = 3;

  logic clk_i, rst_i;
  logic [did_width-1:0] my_did_i;
  logic [lce_id_width-1:0] my_lce_id_i;
  logic lce_req_v_i, lce_req_op_i, lce_req_yumi_o;
  logic [lce_id_width-1:0] lce_req_lce_id_i;
  logic [paddr_width-1:0] lce_req_addr_i;
  logic [data_width-1:0] lce_req_data_i;
  logic lce_cmd_v_o, lce_cmd_op_o, lce_cmd_ready_i;
  logic [lce_id_width-1:0] lce_cmd_lce_id_o;
  logic [paddr_width-1:0] lce_cmd_addr_o;
  logic [data_width-1:0] lce_cmd_data_o;
  logic lce_req_v_o, lce_req_op_o, lce_req_ready_i;
  logic [lce_id_width-1:0] lce_req_lce_id_o;
  logic [paddr_width-1:0] lce_req_addr_o;
  logic [data_width-1:0] lce_req_data_o;
  logic lce_cmd_v_i, lce_cmd_yumi_o;
  logic [data_width-1:0] lce_cmd_data_i;
  logic io_cmd_v_o, io_cmd_op_o, io_cmd_ready_i;
  logic [did_width-1:0] io_cmd_src_did_o, io_cmd_dst_did_o;
  logic [paddr_width-1:0] io_cmd_addr_o;
  logic [data_width-1:0] io_cmd_data_o;
  logic io_resp_v_i, io_resp_op_i, io_resp_ready_o;
  logic [did_width-1:0] io_resp_src_did_i, io_resp_dst_did_i;
  logic [paddr_width-1:0] io_resp_addr_i;
  logic [data_width-1:0] io_resp_data_i;
  logic io_cmd_v_i, io_cmd_op_i, io_cmd_ready_o;
  logic [did_width-1:0] io_cmd_src_did_i, io_cmd_dst_did_i;
  logic [paddr_width-1:0] io_cmd_addr_i;
  logic [data_width-1:0] io_cmd_data_i;
  logic io_resp_v_o, io_resp_op_o, io_resp_ready_i;
  logic [did_width-1:0] io_resp_src_did_o, io_resp_dst_did_o;
  logic [paddr_width-1:0] io_resp_addr_o;
  logic [data_width-1:0] io_resp_data_o;

  logic [15:0] lfsr_q;
  logic bp_en;
  int checks;
  int errors;

  io_tile_top DUT (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Host window goes to the all-ones id, everything else to the top three address bits
  function automatic logic [2:0] expected_dst_did(input logic [15:0] addr);
    if (addr >= 16'h1000 && addr < 16'h2000) begin
      return 3'b111;
    end
    return addr[15:13];
  endfunction

  function automatic logic out_valid(input int sel);
    case (sel)
      out_io_cmd: return io_cmd_v_o;
      out_lce_cmd: return lce_cmd_v_o;
      out_lce_req: return lce_req_v_o;
      default: return io_resp_v_o;
    endcase
  endfunction

  function automatic logic out_taken(input int sel);
    case (sel)
      out_io_cmd: return io_cmd_v_o & io_cmd_ready_i;
      out_lce_cmd: return lce_cmd_v_o & lce_cmd_ready_i;
      out_lce_req: return lce_req_v_o & lce_req_ready_i;
      default: return io_resp_v_o & io_resp_ready_i;
    endcase
  endfunction

  function automatic logic [63:0] out_fields(input int sel);
    case (sel)
      out_io_cmd: return {io_cmd_src_did_o, io_cmd_dst_did_o, io_cmd_op_o, io_cmd_addr_o,
                          io_cmd_data_o};
      out_lce_cmd: return {lce_cmd_lce_id_o, lce_cmd_op_o, lce_cmd_addr_o, lce_cmd_data_o};
      out_lce_req: return {lce_req_lce_id_o, lce_req_op_o, lce_req_addr_o, lce_req_data_o};
      default: return {io_resp_src_did_o, io_resp_dst_did_o, io_resp_op_o, io_resp_addr_o,
                       io_resp_data_o};
    endcase
  endfunction

  function automatic logic in_taken(input int sel);
    case (sel)
      in_lce_req: return lce_req_yumi_o;
      in_io_resp: return io_resp_v_i & io_resp_ready_o;
      in_io_cmd: return io_cmd_v_i & io_cmd_ready_o;
      default: return lce_cmd_yumi_o;
    endcase
  endfunction

  task automatic set_out_ready(input int sel, input logic val);
    case (sel)
      out_io_cmd: io_cmd_ready_i = val;
      out_lce_cmd: lce_cmd_ready_i = val;
      out_lce_req: lce_req_ready_i = val;
      default: io_resp_ready_i = val;
    endcase
  endtask

  task automatic set_in_valid(input int sel, input logic val);
    case (sel)
      in_lce_req: lce_req_v_i = val;
      in_io_resp: io_resp_v_i = val;
      in_io_cmd: io_cmd_v_i = val;
      default: lce_cmd_v_i = val;
    endcase
  endtask

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, got);
    end
  endtask

  // The caller sets the fields and valid stays high until the DUT takes the message
  task automatic offer(input int sel);
    @(posedge clk_i);
    #1;
    set_in_valid(sel, 1'b1);
    @(negedge clk_i);
    while (!in_taken(sel)) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    set_in_valid(sel, 1'b0);
  endtask

  task automatic take_output(input int sel, input string name, output logic [63:0] bits);
    logic held;
    logic [63:0] last;
    held = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      set_out_ready(sel, !bp_en || (lfsr_bit() & lfsr_bit()));
      @(negedge clk_i);
      if (held) begin
        checks++;
        assert (out_valid(sel) && out_fields(sel) == last) else begin
          errors++;
          $display("Error %s: held message changed, expected %h, actual %h",
                   name, last, out_fields(sel));
        end
      end
      if (out_taken(sel)) break;
      held = out_valid(sel);
      last = out_fields(sel);
    end
    bits = out_fields(sel);
    @(posedge clk_i);
    #1;
    set_out_ready(sel, 1'b0);
  endtask

  task automatic check_quiet(input string name);
    @(negedge clk_i);
    checks++;
    assert (!(io_cmd_v_o || lce_cmd_v_o || lce_req_v_o || io_resp_v_o)) else begin
      errors++;
      $display("%s: a message was left over or delivered twice", name);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_outbound(input string name, input logic [1:0] id, input logic op,
                              input logic [15:0] addr, input logic [31:0] wdata,
                              input logic [31:0] rdata);
    logic [63:0] got;
    lce_req_lce_id_i = id;
    lce_req_op_i = op;
    lce_req_addr_i = addr;
    lce_req_data_i = wdata;
    offer(in_lce_req);
    take_output(out_io_cmd, name, got);
    compare(name, {my_did_i, expected_dst_did(addr), op, addr, wdata}, got);
    io_resp_src_did_i = expected_dst_did(addr);
    io_resp_dst_did_i = my_did_i;
    io_resp_op_i = op;
    io_resp_addr_i = addr;
    io_resp_data_i = rdata;
    offer(in_io_resp);
    take_output(out_lce_cmd, name, got);
    compare(name, {id, op, addr, (op == op_load) ? rdata : 32'h0}, got);
    check_quiet(name);
  endtask

  task automatic run_inbound(input string name, input logic [2:0] src, input logic op,
                             input logic [15:0] addr, input logic [31:0] wdata,
                             input logic [31:0] rdata);
    logic [63:0] got;
    io_cmd_src_did_i = src;
    io_cmd_dst_did_i = my_did_i;
    io_cmd_op_i = op;
    io_cmd_addr_i = addr;
    io_cmd_data_i = wdata;
    offer(in_io_cmd);
    take_output(out_lce_req, name, got);
    compare(name, {my_lce_id_i, op, addr, wdata}, got);
    lce_cmd_data_i = rdata;
    offer(in_lce_cmd);
    take_output(out_io_resp, name, got);
    compare(name, {my_did_i, src, op, addr, rdata}, got);
    check_quiet(name);
  endtask

  task automatic test_device_load();
    run_outbound("device_load", 2'd3, op_load, 16'h6a40, 32'h0, 32'hcafe_0123);
  endtask

  task automatic test_host_store();
    run_outbound("host_store", 2'd0, op_store, 16'h1234, 32'hdead_beef, 32'h5555_aaaa);
  endtask

  task automatic test_inbound_cmd();
    run_inbound("inbound_cmd", 3'd5, op_load, 16'h0840, 32'h0102_0304, 32'h89ab_cdef);
  endtask

  task automatic test_back_pressure();
    bp_en = 1'b1;
    run_outbound("bp_load", 2'd2, op_load, 16'hc008, 32'h0, 32'h1357_9bdf);
    run_outbound("bp_store", 2'd1, op_store, 16'h1ffc, 32'h2468_ace0, 32'h7777_0000);
    run_inbound("bp_inbound", 3'd0, op_store, 16'h3010, 32'hfeed_f00d, 32'h0bad_cafe);
    bp_en = 1'b0;
  endtask

  task automatic test_random_traffic();
    logic [15:0] addr;
    logic op;
    logic [1:0] id;
    logic [31:0] wdata;
    logic [31:0] rdata;
    for (int i = 0; i < 16; i++) begin
      addr = 16'(lfsr_bits(16));
      // Every fourth address is forced into the host window
      if (i % 4 == 0) begin
        addr[15:12] = 4'h1;
      end
      op = lfsr_bit();
      id = 2'(lfsr_bits(2));
      wdata = lfsr_bits(32);
      rdata = lfsr_bits(32);
      run_outbound("random_traffic", id, op, addr, wdata, rdata);
    end
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    rst_i = 1'b1;
    my_did_i = 3'd2;
    my_lce_id_i = 2'd1;
    {lce_req_v_i, lce_req_op_i, lce_req_lce_id_i, lce_req_addr_i, lce_req_data_i} = '0;
    {lce_cmd_ready_i, lce_req_ready_i, io_cmd_ready_i, io_resp_ready_i} = '0;
    {lce_cmd_v_i, lce_cmd_data_i} = '0;
    {io_resp_v_i, io_resp_op_i, io_resp_src_did_i, io_resp_dst_did_i} = '0;
    {io_resp_addr_i, io_resp_data_i} = '0;
    {io_cmd_v_i, io_cmd_op_i, io_cmd_src_did_i, io_cmd_dst_did_i} = '0;
    {io_cmd_addr_i, io_cmd_data_i} = '0;
    lfsr_q = 16'd18854;
    bp_en = 1'b0;
    checks = 0;
    errors = 0;
    repeat (reset_cycles) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_quiet("reset");
    test_device_load();
    test_host_store();
    test_inbound_cmd();
    test_back_pressure();
    test_random_traffic();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* flist.f */
hw/io_tile_pkg.sv
hw/io_msg_fifo.sv
hw/io_cce.sv
hw/io_lce_link.sv
hw/io_noc_link.sv
hw/io_tile_top.sv
bench/tb_io_tile.sv
